//--- rtl/ee_bus_if.sv
`timescale 1ns/1ps
`default_nettype none

// Microwire EEPROM serial bus
interface ee_bus_if;
	// Serial clock
	logic sk;
	// Chip select, active high
	logic cs;
	// Data towards the EEPROM
	logic di;
	// Data from the EEPROM, DO on the part
	logic dout;

	// Bus driver side
	modport master (
		output sk,
		output cs,
		output di,
		input dout
	);

	// Device or pin side
	modport pins (
		input sk,
		input cs,
		input di,
		output dout
	);
endinterface

`default_nettype wire

//--- rtl/eeprom_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module eeprom_arbiter (
	input wire aclk,
	input wire arst_n_i,
	input wire rd_req_i,
	input wire sw_req_i,
	output logic rd_gnt_o,
	output nic_pkg::ee_owner_e owner_o,
	ee_bus_if.pins rd_bus,
	ee_bus_if.pins sw_bus,
	ee_bus_if.master pin_bus
);
	import nic_pkg::*;

	ee_owner_e owner_q;
	ee_owner_e owner_n;

	always_comb
	begin
		owner_n = owner_q;
		case (owner_q)
			NONE:
			begin
				// Software wins a free bus
				if (sw_req_i)
					owner_n = SOFTWARE;
				else if (rd_req_i)
					owner_n = READER;
			end
			READER:
			begin
				if (!rd_req_i)
					owner_n = NONE;
			end
			SOFTWARE:
			begin
				if (!sw_req_i)
					owner_n = NONE;
			end
			default:
				owner_n = NONE;
		endcase
	end

	always_ff @(posedge aclk or negedge arst_n_i)
	begin
		if (!arst_n_i)
			owner_q <= NONE;
		else
			owner_q <= owner_n;
	end

	// Pin mux, DO only reaches the owner
	always_comb
	begin
		pin_bus.sk = 1'b0;
		pin_bus.cs = 1'b0;
		pin_bus.di = 1'b0;
		rd_bus.dout = 1'b0;
		sw_bus.dout = 1'b0;
		case (owner_q)
			READER:
			begin
				pin_bus.sk = rd_bus.sk;
				pin_bus.cs = rd_bus.cs;
				pin_bus.di = rd_bus.di;
				rd_bus.dout = pin_bus.dout;
			end
			SOFTWARE:
			begin
				pin_bus.sk = sw_bus.sk;
				pin_bus.cs = sw_bus.cs;
				pin_bus.di = sw_bus.di;
				sw_bus.dout = pin_bus.dout;
			end
			default:
			begin
				// Free bus parks CS and SK low
			end
		endcase
	end

	assign rd_gnt_o = (owner_q == READER);
	assign owner_o = owner_q;

endmodule

`default_nettype wire

//--- rtl/eeprom_reader.sv
`timescale 1ns/1ps
`default_nettype none
`include "nic_settings.svh"

module eeprom_reader (
	input wire aclk,
	input wire arst_n_i,
	input wire rd_start_i,
	input wire [`NIC_EE_ADDR_BITS-1:0] rd_addr_i,
	input wire rd_gnt_i,
	output logic rd_req_o,
	output logic rd_done_o,
	output logic [15:0] rd_data_o,
	output logic done_evt_o,
	ee_bus_if.master bus
);
	import nic_pkg::*;

	// Start bit, READ opcode and address
	localparam int OUT_BITS = `NIC_EE_ADDR_BITS + 3;
	// Dummy zero plus sixteen data bits
	localparam int IN_BITS = 17;
	localparam int DIV_W = $clog2(`NIC_EE_SK_DIV);

	ee_rd_state_e state_q;
	logic [DIV_W-1:0] div_q;
	logic sk_q;
	logic [4:0] bit_q;
	logic [OUT_BITS-1:0] out_q;
	logic [15:0] data_q;
	logic done_q;
	logic tick;

	// Last aclk of an SK half period
	assign tick = (div_q == DIV_W'(`NIC_EE_SK_DIV - 1));

	always_ff @(posedge aclk or negedge arst_n_i)
	begin
		if (!arst_n_i)
		begin
			state_q <= IDLE;
			div_q <= '0;
			sk_q <= 1'b0;
			bit_q <= '0;
			out_q <= '0;
			data_q <= '0;
			done_q <= 1'b0;
		end
		else
		begin
			case (state_q)
				IDLE:
				begin
					if (rd_start_i)
					begin
						out_q <= {3'b110, rd_addr_i};
						done_q <= 1'b0;
						state_q <= REQ;
					end
				end
				REQ:
				begin
					// Wait for the arbiter with SK parked low
					div_q <= '0;
					sk_q <= 1'b0;
					bit_q <= '0;
					if (rd_gnt_i)
						state_q <= SHIFT_OUT;
				end
				SHIFT_OUT:
				begin
					div_q <= tick ? '0 : div_q + 1'b1;
					if (tick)
					begin
						sk_q <= ~sk_q;
						// Next DI bit after each falling edge
						if (sk_q)
						begin
							out_q <= out_q << 1;
							bit_q <= bit_q + 1'b1;
							if (bit_q == 5'(OUT_BITS - 1))
							begin
								bit_q <= '0;
								state_q <= SHIFT_IN;
							end
						end
					end
				end
				SHIFT_IN:
				begin
					div_q <= tick ? '0 : div_q + 1'b1;
					if (tick)
					begin
						sk_q <= ~sk_q;
						if (!sk_q)
						begin
							// Sample DO as SK rises
							// The dummy zero drops off the top after 17 shifts
							data_q <= {data_q[14:0], bus.dout};
							bit_q <= bit_q + 1'b1;
						end
						else if (bit_q == 5'(IN_BITS))
							state_q <= DONE;
					end
				end
				DONE:
				begin
					done_q <= 1'b1;
					state_q <= IDLE;
				end
				default:
					state_q <= IDLE;
			endcase
		end
	end

	// Bus held from request until the last SK falls
	assign rd_req_o = (state_q == REQ) || (state_q == SHIFT_OUT) || (state_q == SHIFT_IN);
	assign rd_done_o = done_q;
	assign rd_data_o = data_q;
	assign done_evt_o = (state_q == DONE);
	assign bus.sk = sk_q;
	assign bus.cs = (state_q == SHIFT_OUT) || (state_q == SHIFT_IN);
	assign bus.di = (state_q == SHIFT_OUT) && out_q[OUT_BITS-1];

endmodule

`default_nettype wire

//--- rtl/intr_ctrl.sv
`timescale 1ns/1ps
`default_nettype none
`include "nic_settings.svh"

module intr_ctrl (
	input wire aclk,
	input wire arst_n_i,
	input wire ics_wr_i,
	input wire ims_wr_i,
	input wire imc_wr_i,
	input wire icr_rd_i,
	input wire [`NIC_INTR_BITS-1:0] wdata_i,
	input wire ee_done_evt_i,
	input wire phy_int_i,
	output logic [`NIC_INTR_BITS-1:0] icr_o,
	output logic [`NIC_INTR_BITS-1:0] ims_o,
	output logic intr_o
);
	logic [1:0] phy_sync_q;
	logic phy_prev_q;
	logic phy_rise;
	logic [`NIC_INTR_BITS-1:0] icr_q;
	logic [`NIC_INTR_BITS-1:0] ims_q;
	logic [`NIC_INTR_BITS-1:0] set_causes;

	// Edge of the synchronized PHY line
	assign phy_rise = phy_sync_q[1] && !phy_prev_q;

	// Hardware events plus software ICS writes
	always_comb
	begin
		set_causes = ics_wr_i ? wdata_i : '0;
		set_causes[`NIC_INTR_EE_DONE] = set_causes[`NIC_INTR_EE_DONE] | ee_done_evt_i;
		set_causes[`NIC_INTR_PHY] = set_causes[`NIC_INTR_PHY] | phy_rise;
	end

	always_ff @(posedge aclk or negedge arst_n_i)
	begin
		if (!arst_n_i)
		begin
			phy_sync_q <= '0;
			phy_prev_q <= 1'b0;
			icr_q <= '0;
			ims_q <= '0;
			intr_o <= 1'b0;
		end
		else
		begin
			phy_sync_q <= {phy_sync_q[0], phy_int_i};
			phy_prev_q <= phy_sync_q[1];
			// Read clears, a new cause in the same cycle survives
			icr_q <= (icr_rd_i ? '0 : icr_q) | set_causes;
			if (ims_wr_i)
				ims_q <= ims_q | wdata_i;
			else if (imc_wr_i)
				ims_q <= ims_q & ~wdata_i;
			intr_o <= |(icr_q & ims_q);
		end
	end

	assign icr_o = icr_q;
	assign ims_o = ims_q;

endmodule

`default_nettype wire

//--- rtl/nic_mgmt_top.sv
`timescale 1ns/1ps
`default_nettype none
`include "nic_settings.svh"

module nic_mgmt_top (
	input wire aclk,
	input wire arst_n_i,
	input wire reg_valid_i,
	input wire reg_write_i,
	input wire [7:0] reg_addr_i,
	input wire [31:0] reg_wdata_i,
	input wire phy_int_i,
	input wire ee_do_i,
	output wire reg_ack_o,
	output wire [31:0] reg_rdata_o,
	output wire intr_o,
	output wire ee_sk_o,
	output wire ee_cs_o,
	output wire ee_di_o
);
	import nic_pkg::*;

	// Reader side, software side and the shared pins
	ee_bus_if rd_if ();
	ee_bus_if sw_if ();
	ee_bus_if pin_if ();

	logic rd_start;
	logic [`NIC_EE_ADDR_BITS-1:0] rd_addr;
	logic rd_done;
	logic [15:0] rd_data;
	logic rd_req;
	logic rd_gnt;
	logic done_evt;
	logic sw_req;
	ee_owner_e owner;
	logic ics_wr;
	logic ims_wr;
	logic imc_wr;
	logic icr_rd;
	logic [`NIC_INTR_BITS-1:0] intr_wdata;
	logic [`NIC_INTR_BITS-1:0] icr;
	logic [`NIC_INTR_BITS-1:0] ims;

	nic_regs regs0 (
		.aclk(aclk), .arst_n_i(arst_n_i),
		.reg_valid_i(reg_valid_i), .reg_write_i(reg_write_i),
		.reg_addr_i(reg_addr_i), .reg_wdata_i(reg_wdata_i),
		.rd_done_i(rd_done), .rd_data_i(rd_data), .owner_i(owner),
		.icr_i(icr), .ims_i(ims),
		.reg_ack_o(reg_ack_o), .reg_rdata_o(reg_rdata_o),
		.rd_start_o(rd_start), .rd_addr_o(rd_addr), .sw_req_o(sw_req),
		.ics_wr_o(ics_wr), .ims_wr_o(ims_wr), .imc_wr_o(imc_wr), .icr_rd_o(icr_rd),
		.wdata_o(intr_wdata), .sw_bus(sw_if.master)
	);

	eeprom_reader reader0 (
		.aclk(aclk), .arst_n_i(arst_n_i),
		.rd_start_i(rd_start), .rd_addr_i(rd_addr), .rd_gnt_i(rd_gnt),
		.rd_req_o(rd_req), .rd_done_o(rd_done), .rd_data_o(rd_data),
		.done_evt_o(done_evt), .bus(rd_if.master)
	);

	eeprom_arbiter arb0 (
		.aclk(aclk), .arst_n_i(arst_n_i),
		.rd_req_i(rd_req), .sw_req_i(sw_req),
		.rd_gnt_o(rd_gnt), .owner_o(owner),
		.rd_bus(rd_if.pins), .sw_bus(sw_if.pins), .pin_bus(pin_if.master)
	);

	intr_ctrl intr0 (
		.aclk(aclk), .arst_n_i(arst_n_i),
		.ics_wr_i(ics_wr), .ims_wr_i(ims_wr), .imc_wr_i(imc_wr), .icr_rd_i(icr_rd),
		.wdata_i(intr_wdata), .ee_done_evt_i(done_evt), .phy_int_i(phy_int_i),
		.icr_o(icr), .ims_o(ims), .intr_o(intr_o)
	);

	// Pin bus onto the package pins
	assign ee_sk_o = pin_if.sk;
	assign ee_cs_o = pin_if.cs;
	assign ee_di_o = pin_if.di;
	assign pin_if.dout = ee_do_i;

endmodule

`default_nettype wire

//--- rtl/nic_pkg.sv
`default_nettype none
`include "nic_settings.svh"

package nic_pkg;

	// Decoded register offsets
	typedef enum logic [7:0] {
		REG_EECD = `NIC_EECD_ADDR,
		REG_EERD = `NIC_EERD_ADDR,
		REG_ICR = `NIC_ICR_ADDR,
		REG_ICS = `NIC_ICS_ADDR,
		REG_IMS = `NIC_IMS_ADDR,
		REG_IMC = `NIC_IMC_ADDR
	} reg_addr_e;

	// Steps of one automatic word read
	typedef enum logic [2:0] {
		IDLE,
		REQ,
		SHIFT_OUT,
		SHIFT_IN,
		DONE
	} ee_rd_state_e;

	// Holder of the shared EEPROM pins
	typedef enum logic [1:0] {
		NONE,
		READER,
		SOFTWARE
	} ee_owner_e;

endpackage

`default_nettype wire

//--- rtl/nic_regs.sv
`timescale 1ns/1ps
`default_nettype none
`include "nic_settings.svh"

module nic_regs (
	input wire aclk,
	input wire arst_n_i,
	input wire reg_valid_i,
	input wire reg_write_i,
	input wire [7:0] reg_addr_i,
	input wire [31:0] reg_wdata_i,
	input wire rd_done_i,
	input wire [15:0] rd_data_i,
	input wire nic_pkg::ee_owner_e owner_i,
	input wire [`NIC_INTR_BITS-1:0] icr_i,
	input wire [`NIC_INTR_BITS-1:0] ims_i,
	output logic reg_ack_o,
	output logic [31:0] reg_rdata_o,
	output logic rd_start_o,
	output logic [`NIC_EE_ADDR_BITS-1:0] rd_addr_o,
	output logic sw_req_o,
	output logic ics_wr_o,
	output logic ims_wr_o,
	output logic imc_wr_o,
	output logic icr_rd_o,
	output logic [`NIC_INTR_BITS-1:0] wdata_o,
	ee_bus_if.master sw_bus
);
	import nic_pkg::*;

	reg_addr_e addr;
	logic wr;
	logic rd;
	logic eecd_sk_q;
	logic eecd_cs_q;
	logic eecd_di_q;
	logic eecd_req_q;
	logic [`NIC_EE_ADDR_BITS-1:0] eerd_addr_q;
	logic start_q;
	logic ack_q;
	logic [31:0] rdata_q;
	logic [31:0] rdata_n;

	assign addr = reg_addr_e'(reg_addr_i);
	assign wr = reg_valid_i && reg_write_i;
	assign rd = reg_valid_i && !reg_write_i;

	// Interrupt strobes act at the same edge as the request
	assign ics_wr_o = wr && (addr == REG_ICS);
	assign ims_wr_o = wr && (addr == REG_IMS);
	assign imc_wr_o = wr && (addr == REG_IMC);
	assign icr_rd_o = rd && (addr == REG_ICR);
	assign wdata_o = reg_wdata_i[`NIC_INTR_BITS-1:0];

	always_ff @(posedge aclk or negedge arst_n_i)
	begin
		if (!arst_n_i)
		begin
			ack_q <= 1'b0;
			start_q <= 1'b0;
			eecd_sk_q <= 1'b0;
			eecd_cs_q <= 1'b0;
			eecd_di_q <= 1'b0;
			eecd_req_q <= 1'b0;
			eerd_addr_q <= '0;
		end
		else
		begin
			// Every request gets its ack one cycle later
			ack_q <= reg_valid_i;
			// Start pulse lines up with the latched address
			start_q <= wr && (addr == REG_EERD) && reg_wdata_i[`NIC_EERD_START];
			if (wr && (addr == REG_EECD))
			begin
				eecd_sk_q <= reg_wdata_i[`NIC_EECD_SK];
				eecd_cs_q <= reg_wdata_i[`NIC_EECD_CS];
				eecd_di_q <= reg_wdata_i[`NIC_EECD_DI];
				eecd_req_q <= reg_wdata_i[`NIC_EECD_REQ];
			end
			if (wr && (addr == REG_EERD))
				eerd_addr_q <= reg_wdata_i[`NIC_EERD_ADDR_LSB +: `NIC_EE_ADDR_BITS];
		end
	end

	// Read-back from live status
	always_comb
	begin
		rdata_n = '0;
		case (addr)
			REG_EECD:
			begin
				rdata_n[`NIC_EECD_SK] = eecd_sk_q;
				rdata_n[`NIC_EECD_CS] = eecd_cs_q;
				rdata_n[`NIC_EECD_DI] = eecd_di_q;
				rdata_n[`NIC_EECD_DO] = sw_bus.dout;
				rdata_n[`NIC_EECD_REQ] = eecd_req_q;
				rdata_n[`NIC_EECD_GNT] = (owner_i == SOFTWARE);
			end
			REG_EERD:
			begin
				rdata_n[`NIC_EERD_DONE] = rd_done_i;
				rdata_n[`NIC_EERD_ADDR_LSB +: `NIC_EE_ADDR_BITS] = eerd_addr_q;
				rdata_n[`NIC_EERD_DATA_LSB +: 16] = rd_data_i;
			end
			REG_ICR:
				rdata_n[`NIC_INTR_BITS-1:0] = icr_i;
			REG_IMS:
				rdata_n[`NIC_INTR_BITS-1:0] = ims_i;
			// ICS, IMC and unmapped offsets read as zero
			default:
				rdata_n = '0;
		endcase
	end

	// Read data captured with the request
	always_ff @(posedge aclk)
	begin
		if (rd)
			rdata_q <= rdata_n;
	end

	assign reg_ack_o = ack_q;
	assign reg_rdata_o = rdata_q;
	assign rd_start_o = start_q;
	assign rd_addr_o = eerd_addr_q;
	assign sw_req_o = eecd_req_q;
	// Software pins follow EECD directly
	assign sw_bus.sk = eecd_sk_q;
	assign sw_bus.cs = eecd_cs_q;
	assign sw_bus.di = eecd_di_q;

endmodule

`default_nettype wire

//--- rtl/nic_settings.svh
`ifndef NIC_SETTINGS_SVH
`define NIC_SETTINGS_SVH

// Register byte offsets on the host port
`define NIC_EECD_ADDR 8'h10
`define NIC_EERD_ADDR 8'h14
`define NIC_ICR_ADDR 8'hC0
`define NIC_ICS_ADDR 8'hC8
`define NIC_IMS_ADDR 8'hD0
`define NIC_IMC_ADDR 8'hD8

// aclk cycles per SK half period
`define NIC_EE_SK_DIV 4
// Word address width of the EEPROM
`define NIC_EE_ADDR_BITS 6

// Interrupt cause count and bit positions
`define NIC_INTR_BITS 2
`define NIC_INTR_EE_DONE 0
`define NIC_INTR_PHY 1

// EECD fields
`define NIC_EECD_SK 0
`define NIC_EECD_CS 1
`define NIC_EECD_DI 2
`define NIC_EECD_DO 3
`define NIC_EECD_REQ 6
`define NIC_EECD_GNT 7

// EERD fields
`define NIC_EERD_START 0
`define NIC_EERD_DONE 4
`define NIC_EERD_ADDR_LSB 8
`define NIC_EERD_DATA_LSB 16

`endif

//--- sources.f
+incdir+rtl
rtl/nic_pkg.sv
rtl/ee_bus_if.sv
rtl/nic_regs.sv
rtl/eeprom_reader.sv
rtl/eeprom_arbiter.sv
rtl/intr_ctrl.sv
rtl/nic_mgmt_top.sv
verif/eeprom_model.sv
verif/tb_nic_mgmt.sv

//--- verif/eeprom_model.sv
`timescale 1ns/1ps
`default_nettype none

// Microwire serial EEPROM, READ command only
module eeprom_model (
	input wire sk_i,
	input wire cs_i,
	input wire di_i,
	output logic do_o
);
	localparam logic [31:0] SEED = 32'd40714;

	logic [15:0] mem [0:63];
	logic [31:0] fill;
	// Start bit seen
	logic started = 1'b0;
	// Opcode and address bits received so far
	int in_cnt = 0;
	logic [7:0] cmd = '0;
	logic reading = 1'b0;
	logic [15:0] word_q = '0;

	function automatic logic [31:0] lcg_next(input logic [31:0] state);
		return state * 32'd1103515245 + 32'd12345;
	endfunction

	// Word i takes the upper half of LCG step i+1
	initial
	begin
		do_o = 1'b0;
		fill = SEED;
		for (int i = 0; i < 64; i++)
		begin
			fill = lcg_next(fill);
			mem[i] = fill[31:16];
		end
	end

	// Command bits sampled as SK rises
	always @(posedge sk_i or negedge cs_i)
	begin
		if (!cs_i)
		begin
			started <= 1'b0;
			in_cnt <= 0;
		end
		else if (!started)
			started <= di_i;
		else if (in_cnt < 8)
		begin
			cmd <= {cmd[6:0], di_i};
			in_cnt <= in_cnt + 1;
		end
	end

	// Data out as SK falls, dummy zero first
	always @(negedge sk_i or negedge cs_i)
	begin
		if (!cs_i)
		begin
			reading <= 1'b0;
			do_o <= 1'b0;
		end
		else if (in_cnt == 8 && cmd[7:6] == 2'b10)
		begin
			if (!reading)
			begin
				reading <= 1'b1;
				word_q <= mem[cmd[5:0]];
				do_o <= 1'b0;
			end
			else
			begin
				// MSB first
				do_o <= word_q[15];
				word_q <= {word_q[14:0], 1'b0};
			end
		end
	end

endmodule

`default_nettype wire

//--- verif/tb_nic_mgmt.sv
`timescale 1ns/1ps
`default_nettype none
`include "nic_settings.svh"

module tb_nic_mgmt;
	import nic_pkg::*;

	localparam logic [31:0] SEED = 32'd40714;
	localparam int SK_CYCLES = 2 * `NIC_EE_SK_DIV;
	// Eight word reads of about 26 SK periods plus register traffic
	localparam int TIMEOUT_CYCLES = 8 * 26 * SK_CYCLES + 2000;
	// EERD polls of two cycles that outlast one whole word read
	localparam int HOLD_POLLS = (26 * SK_CYCLES + 3) / 2 + 8;
	localparam logic [31:0] EECD_SK = 32'h1 << `NIC_EECD_SK;
	localparam logic [31:0] EECD_CS = 32'h1 << `NIC_EECD_CS;
	localparam logic [31:0] EECD_DI = 32'h1 << `NIC_EECD_DI;
	localparam logic [31:0] EECD_REQ = 32'h1 << `NIC_EECD_REQ;
	localparam logic [31:0] EECD_GNT = 32'h1 << `NIC_EECD_GNT;

	logic aclk;
	logic arst_n;
	logic reg_valid;
	logic reg_write;
	logic [7:0] reg_addr;
	logic [31:0] reg_wdata;
	logic phy_int;
	logic reg_ack;
	logic [31:0] reg_rdata;
	logic intr;
	logic ee_sk;
	logic ee_cs;
	logic ee_di;
	logic ee_do;

	// Pending compares
	string name_q[$];
	logic [31:0] exp_q[$];
	logic [31:0] act_q[$];
	string chk_name;
	logic [31:0] chk_exp;
	logic [31:0] chk_act;
	int checks = 0;
	int mismatches = 0;
	int failures = 0;
	int cycles = 0;

	logic [31:0] rng;
	logic [1:0] icr_exp;
	logic [1:0] ims_exp;
	logic [31:0] rdata;
	logic [5:0] addr;
	logic [15:0] word;

	nic_mgmt_top dut0 (
		.aclk(aclk),
		.arst_n_i(arst_n),
		.reg_valid_i(reg_valid),
		.reg_write_i(reg_write),
		.reg_addr_i(reg_addr),
		.reg_wdata_i(reg_wdata),
		.phy_int_i(phy_int),
		.ee_do_i(ee_do),
		.reg_ack_o(reg_ack),
		.reg_rdata_o(reg_rdata),
		.intr_o(intr),
		.ee_sk_o(ee_sk),
		.ee_cs_o(ee_cs),
		.ee_di_o(ee_di)
	);

	eeprom_model ee0 (
		.sk_i(ee_sk),
		.cs_i(ee_cs),
		.di_i(ee_di),
		.do_o(ee_do)
	);

	// 100 ns clock
	initial
	begin
		aclk = 1'b0;
		forever
			#50 aclk = ~aclk;
	end

	function automatic logic [31:0] lcg_next(input logic [31:0] state);
		return state * 32'd1103515245 + 32'd12345;
	endfunction

	// Expected EEPROM word is LCG step a+1 from the seed
	function automatic logic [15:0] ee_word(input logic [5:0] a);
		logic [31:0] state;
		state = SEED;
		for (int i = 0; i <= a; i++)
			state = lcg_next(state);
		return state[31:16];
	endfunction

	// Interrupt line is any enabled cause
	function automatic logic exp_intr(input logic [1:0] icr, input logic [1:0] ims);
		return |(icr & ims);
	endfunction

	task automatic queue_check(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		name_q.push_back(name);
		exp_q.push_back(expected);
		act_q.push_back(actual);
	endtask

	// One strobe with the data taken at the ack on the next cycle
	task automatic reg_access(input logic write, input logic [7:0] a, input logic [31:0] wdata,
		output logic [31:0] data);
		@(negedge aclk);
		// Previous ack lasted one cycle only
		queue_check("reg_ack_o", 0, reg_ack);
		reg_valid = 1'b1;
		reg_write = write;
		reg_addr = a;
		reg_wdata = wdata;
		@(negedge aclk);
		reg_valid = 1'b0;
		reg_write = 1'b0;
		queue_check("reg_ack_o", 1, reg_ack);
		data = reg_rdata;
	endtask

	task automatic reg_write_word(input logic [7:0] a, input logic [31:0] wdata);
		logic [31:0] unused;
		reg_access(1'b1, a, wdata, unused);
	endtask

	task automatic reg_read_word(input logic [7:0] a, output logic [31:0] data);
		reg_access(1'b0, a, 32'h0, data);
	endtask

	// Poll EECD for GNT
	task automatic wait_gnt(output logic [31:0] val);
		int polls;
		polls = 0;
		reg_read_word(REG_EECD, val);
		while (!val[`NIC_EECD_GNT] && polls < 8)
		begin
			reg_read_word(REG_EECD, val);
			polls++;
		end
		assert (val[`NIC_EECD_GNT]) else
		begin
			failures++;
			$display("ERROR: software request on EECD was never granted");
		end
	endtask

	task automatic eerd_start(input logic [5:0] a);
		reg_write_word(REG_EERD, {18'h0, a, 8'h01});
	endtask

	// Poll EERD for DONE
	task automatic eerd_poll(output logic [31:0] val);
		int polls;
		polls = 0;
		reg_read_word(REG_EERD, val);
		while (!val[`NIC_EERD_DONE] && polls < 200)
		begin
			reg_read_word(REG_EERD, val);
			polls++;
		end
		assert (val[`NIC_EERD_DONE]) else
		begin
			failures++;
			$display("ERROR: EERD read never reported DONE");
		end
	endtask

	// Bit-banged READ through EECD
	task automatic sw_read_word(input logic [5:0] a, output logic [15:0] data);
		logic [8:0] cmd;
		logic [31:0] di;
		logic [31:0] val;
		cmd = {3'b110, a};
		data = '0;
		reg_write_word(REG_EECD, EECD_REQ | EECD_CS);
		for (int i = 8; i >= 0; i--)
		begin
			di = cmd[i] ? EECD_DI : 32'h0;
			reg_write_word(REG_EECD, EECD_REQ | EECD_CS | di);
			reg_write_word(REG_EECD, EECD_REQ | EECD_CS | EECD_SK | di);
		end
		// Last falling edge brings the dummy zero
		reg_write_word(REG_EECD, EECD_REQ | EECD_CS);
		for (int i = 0; i < 16; i++)
		begin
			reg_write_word(REG_EECD, EECD_REQ | EECD_CS | EECD_SK);
			reg_write_word(REG_EECD, EECD_REQ | EECD_CS);
			reg_read_word(REG_EECD, val);
			data = {data[14:0], val[`NIC_EECD_DO]};
		end
		reg_write_word(REG_EECD, EECD_REQ);
	endtask

	// intr_o is registered one cycle after the cause or mask
	task automatic check_intr();
		@(negedge aclk);
		queue_check("intr_o", exp_intr(icr_exp, ims_exp), intr);
	endtask

	// Compare process
	always @(negedge aclk)
	begin
		while (exp_q.size() > 0)
		begin
			chk_name = name_q.pop_front();
			chk_exp = exp_q.pop_front();
			chk_act = act_q.pop_front();
			checks++;
			assert (chk_act === chk_exp) else
			begin
				mismatches++;
				$display("MISMATCH %s: expected 0x%h, got 0x%h", chk_name, chk_exp, chk_act);
			end
		end
	end

	// Watchdog
	initial
	begin
		while (cycles < TIMEOUT_CYCLES)
		begin
			@(posedge aclk);
			cycles++;
		end
		$display("ERROR: run stopped by timeout after %0d cycles", cycles);
		$display("Checks: %0d, mismatches: %0d, other errors: %0d", checks, mismatches,
			failures + 1);
		$display("Simulation finished: FAIL");
		$finish;
	end

	initial
	begin
		arst_n = 1'b0;
		reg_valid = 1'b0;
		reg_write = 1'b0;
		reg_addr = 8'h0;
		reg_wdata = 32'h0;
		phy_int = 1'b0;
		rng = SEED;
		icr_exp = '0;
		ims_exp = '0;
		repeat (8) @(negedge aclk);
		arst_n = 1'b1;

		// Reset values
		@(negedge aclk);
		queue_check("intr_o", 0, intr);
		queue_check("ee_cs_o", 0, ee_cs);
		queue_check("ee_sk_o", 0, ee_sk);
		queue_check("reg_ack_o", 0, reg_ack);
		reg_read_word(REG_EECD, rdata);
		queue_check("EECD", 0, rdata);
		reg_read_word(REG_EERD, rdata);
		queue_check("EERD", 0, rdata);
		reg_read_word(REG_ICR, rdata);
		queue_check("ICR", 0, rdata);
		reg_read_word(REG_IMS, rdata);
		queue_check("IMS", 0, rdata);

		// Automatic reads at random addresses
		repeat (6)
		begin
			rng = lcg_next(rng);
			addr = rng[29:24];
			eerd_start(addr);
			eerd_poll(rdata);
			queue_check("EERD", {ee_word(addr), 2'b00, addr, 8'h10}, rdata);
		end

		// Software owns the pins
		reg_write_word(REG_EECD, EECD_REQ);
		wait_gnt(rdata);
		queue_check("EECD", EECD_REQ | EECD_GNT, rdata);
		reg_write_word(REG_EECD, EECD_REQ | EECD_CS | EECD_DI);
		queue_check("ee_cs_o", 1, ee_cs);
		queue_check("ee_di_o", 1, ee_di);
		queue_check("ee_sk_o", 0, ee_sk);
		reg_write_word(REG_EECD, EECD_REQ | EECD_CS | EECD_SK);
		queue_check("ee_sk_o", 1, ee_sk);
		queue_check("ee_di_o", 0, ee_di);
		reg_write_word(REG_EECD, EECD_REQ);
		queue_check("ee_cs_o", 0, ee_cs);
		rng = lcg_next(rng);
		addr = rng[29:24];
		sw_read_word(addr, word);
		queue_check("EECD DO word", ee_word(addr), word);
		reg_write_word(REG_EECD, 32'h0);

		// Reader waits while software holds the bus
		reg_write_word(REG_EECD, EECD_REQ | EECD_CS);
		wait_gnt(rdata);
		rng = lcg_next(rng);
		addr = rng[29:24];
		eerd_start(addr);
		repeat (HOLD_POLLS)
		begin
			reg_read_word(REG_EERD, rdata);
			queue_check("EERD DONE", 0, rdata[`NIC_EERD_DONE]);
			queue_check("ee_cs_o", 1, ee_cs);
			queue_check("ee_sk_o", 0, ee_sk);
		end
		reg_write_word(REG_EECD, EECD_REQ);
		queue_check("ee_cs_o", 0, ee_cs);
		reg_write_word(REG_EECD, 32'h0);
		eerd_poll(rdata);
		queue_check("EERD", {ee_word(addr), 2'b00, addr, 8'h10}, rdata);

		// Finished reads left cause 0 and a read clears it
		reg_read_word(REG_ICR, rdata);
		queue_check("ICR", 32'h1, rdata);
		reg_read_word(REG_ICR, rdata);
		queue_check("ICR", 32'h0, rdata);
		reg_write_word(REG_IMS, 32'h3);
		ims_exp = 2'b11;
		reg_read_word(REG_IMS, rdata);
		queue_check("IMS", ims_exp, rdata);
		check_intr();
		reg_write_word(REG_ICS, 32'h1);
		icr_exp = 2'b01;
		check_intr();
		reg_write_word(REG_IMC, 32'h1);
		ims_exp = 2'b10;
		check_intr();
		reg_read_word(REG_IMS, rdata);
		queue_check("IMS", ims_exp, rdata);
		reg_write_word(REG_ICS, 32'h2);
		icr_exp = 2'b11;
		check_intr();
		reg_read_word(REG_ICR, rdata);
		queue_check("ICR", icr_exp, rdata);
		icr_exp = 2'b00;
		check_intr();
		reg_write_word(REG_IMS, 32'h1);
		ims_exp = 2'b11;

		// PHY edge to intr_o in exactly 4 cycles
		@(negedge aclk);
		phy_int = 1'b1;
		for (int k = 1; k <= 4; k++)
		begin
			@(negedge aclk);
			queue_check("intr_o", (k == 4), intr);
		end
		icr_exp = 2'b10;
		reg_read_word(REG_ICR, rdata);
		queue_check("ICR", icr_exp, rdata);
		phy_int = 1'b0;

		// Let the compare process drain
		repeat (2) @(negedge aclk);
		$display("Checks: %0d, mismatches: %0d, other errors: %0d", checks, mismatches, failures);
		if (mismatches == 0 && failures == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

`default_nettype wire
